// File: files.f
+incdir+include
verilog/trace_pkg.sv
verilog/cycle_timer.sv
verilog/core_trace_decoder.sv
verilog/event_fsm.sv
verilog/trace_unit.sv
verif/tb_trace_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the trace unit simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   -f files.f \
   --top-module tb_trace_unit \
   -Mdir obj_dir -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
   echo "Build failed, see build.log"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Verification passed" sim.log; then
   exit 0
else
   echo "Pass message not found in sim.log"
   exit 1
fi

// File: include/trace_tb_model.svh
// Trace unit reference model
`ifndef TRACE_TB_MODEL_SVH
`define TRACE_TB_MODEL_SVH

// Dimensions of the modelled unit
localparam int MDL_NUM_CORES = 2;
localparam int MDL_TS_WIDTH  = 16;

typedef struct {
   trace_pkg::event_code_e     code;
   logic [trace_pkg::XLEN-1:0] data;
   logic [MDL_TS_WIDTH-1:0]    stamp;
} mdl_event_t;

logic [trace_pkg::XLEN-1:0] mdl_r3     [MDL_NUM_CORES];
bit                         mdl_exited [MDL_NUM_CORES];
mdl_event_t                 mdl_exp    [MDL_NUM_CORES][$];
// Mirrors the timer
// Zero in the first cycle after reset
logic [MDL_TS_WIDTH-1:0]    mdl_cycle;

function automatic void reset_model();
   for (int c = 0; c < MDL_NUM_CORES; c++) begin
      mdl_r3[c]     = '0;
      mdl_exited[c] = 1'b0;
      mdl_exp[c].delete();
   end
   mdl_cycle = '0;
endfunction

// Once per rising edge after reset
// Called after the trace entries of that edge
function automatic void advance_model_cycle();
   mdl_cycle = mdl_cycle + 1'b1;
endfunction

// One valid trace entry sampled at the current edge
function automatic void apply_trace_entry(input int core, input logic [31:0] insn,
                                          input logic wben, input logic [4:0] wbreg,
                                          input logic [trace_pkg::XLEN-1:0] wbdata);
   mdl_event_t ev;
   bit         hit;
   hit      = 1'b1;
   ev.code  = trace_pkg::EV_REPORT;
   ev.data  = mdl_r3[core];
   ev.stamp = mdl_cycle;
   case (insn[15:0])
      trace_pkg::NOP_K_EXIT:    ev.code = trace_pkg::EV_EXIT;
      trace_pkg::NOP_K_REPORT:  ev.code = trace_pkg::EV_REPORT;
      trace_pkg::NOP_K_PUTCHAR: begin
         ev.code = trace_pkg::EV_PUTCHAR;
         ev.data = {{(trace_pkg::XLEN-8){1'b0}}, mdl_r3[core][7:0]};
      end
      default:                  hit = 1'b0;
   endcase
   if ((insn[31:16] == trace_pkg::NOP_OPCODE) && hit && !mdl_exited[core]) begin
      mdl_exp[core].push_back(ev);
      if (ev.code == trace_pkg::EV_EXIT) begin
         mdl_exited[core] = 1'b1;
      end
   end
   // Writeback lands after the event took the old value
   if (wben && (wbreg == trace_pkg::REG_R3)) begin
      mdl_r3[core] = wbdata;
   end
endfunction

// Newest expected event of a core is lost to overflow
function automatic void drop_newest_event(input int core);
   if (mdl_exp[core].size() > 0) begin
      void'(mdl_exp[core].pop_back());
   end
endfunction

`endif

// File: verif/tb_trace_unit.sv
// Trace unit testbench
`timescale 1ns/100ps

module tb_trace_unit;

   localparam int NUM_CORES   = 2;
   localparam int TS_WIDTH    = 16;
   localparam int MAIN_CYCLES = 400;
   // Main traffic lane cycles plus three stalled no-ops
   // Exit phase sends one exit and two later no-ops per core
   localparam int ENTRY_COUNT = NUM_CORES * MAIN_CYCLES + 3 + 3 * NUM_CORES;
   localparam int CYCLE_LIMIT = 40 * ENTRY_COUNT + 200;
   localparam int NOP_GAP     = 30;

   logic                                   clk;
   logic                                   arst_n;
   logic [NUM_CORES-1:0]                   trace_valid;
   logic [NUM_CORES*trace_pkg::INSN_W-1:0] trace_insn;
   logic [NUM_CORES-1:0]                   trace_wben;
   logic [NUM_CORES*trace_pkg::REG_W-1:0]  trace_wbreg;
   logic [NUM_CORES*trace_pkg::XLEN-1:0]   trace_wbdata;
   logic                                   event_req;
   logic                                   event_ack;
   trace_pkg::event_code_e                 event_code;
   logic [0:0]                             event_core;
   logic [trace_pkg::XLEN-1:0]             event_data;
   logic [TS_WIDTH-1:0]                    event_time;
   logic                                   done;
   logic                                   overflow;

   int   seed = 25689;
   int   cycle_count;
   bit   ack_paused;
   int   ack_wait;
   logic req_q;
   bit   done_seen;
   logic [63:0] held_fields;
   int   cooldown [NUM_CORES];

   `include "trace_tb_model.svh"

   trace_unit #(
      .NUM_CORES (NUM_CORES),
      .TS_WIDTH  (TS_WIDTH)
   ) trace_unit_i (
      .clk_i          (clk),
      .arst_n_i       (arst_n),
      .trace_valid_i  (trace_valid),
      .trace_insn_i   (trace_insn),
      .trace_wben_i   (trace_wben),
      .trace_wbreg_i  (trace_wbreg),
      .trace_wbdata_i (trace_wbdata),
      .event_req_o    (event_req),
      .event_ack_i    (event_ack),
      .event_code_o   (event_code),
      .event_core_o   (event_core),
      .event_data_o   (event_data),
      .event_time_o   (event_time),
      .done_o         (done),
      .overflow_o     (overflow)
   );

   // 20 ns clock
   always #10 clk = ~clk;

   task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                              input string msg);
      if (actual !== expected) begin
         $display("** Error at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
         $display("Verification failed");
         $fatal(1);
      end
   endtask

   // Drive one lane for the coming cycle
   task automatic drive_lane(input int core, input logic valid, input logic [31:0] insn,
                             input logic wben, input logic [4:0] wbreg,
                             input logic [31:0] wbdata);
      trace_valid[core]            <= valid;
      trace_insn[core*32 +: 32]    <= insn;
      trace_wben[core]             <= wben;
      trace_wbreg[core*5 +: 5]     <= wbreg;
      trace_wbdata[core*32 +: 32]  <= wbdata;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         for (int c = 0; c < NUM_CORES; c++) begin
            drive_lane(c, 1'b0, 32'h0, 1'b0, 5'd0, 32'h0);
         end
      end
   endtask

   // One no-op on one core while the other lanes stay quiet
   task automatic send_nop(input int core, input logic [15:0] k);
      @(posedge clk);
      for (int c = 0; c < NUM_CORES; c++) begin
         drive_lane(c, 1'b0, 32'h0, 1'b0, 5'd0, 32'h0);
      end
      drive_lane(core, 1'b1, {trace_pkg::NOP_OPCODE, k}, 1'b0, 5'd0, 32'h0);
   endtask

   function automatic bit model_empty();
      for (int c = 0; c < NUM_CORES; c++) begin
         if (mdl_exp[c].size() != 0) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   // Exit seen by the model on every core
   function automatic bit cores_all_exited();
      for (int c = 0; c < NUM_CORES; c++) begin
         if (!mdl_exited[c]) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   // Until every expected event went through the port
   task automatic wait_drain();
      @(posedge clk);
      while (!model_empty() || event_req || event_ack) begin
         @(posedge clk);
      end
   endtask

   // Model follows every sampled trace entry
   always @(posedge clk) begin
      if (arst_n) begin
         for (int c = 0; c < NUM_CORES; c++) begin
            if (trace_valid[c]) begin
               apply_trace_entry(c, trace_insn[c*32 +: 32], trace_wben[c],
                                 trace_wbreg[c*5 +: 5], trace_wbdata[c*32 +: 32]);
            end
         end
         advance_model_cycle();
      end
   end

   // Host side acks after 0 to 3 cycles each way
   always @(posedge clk) begin
      if (arst_n) begin
         if (!event_ack) begin
            if (event_req && !ack_paused) begin
               if (ack_wait == 0) begin
                  event_ack <= 1'b1;
                  ack_wait  <= $random(seed) & 3;
               end else begin
                  ack_wait <= ack_wait - 1;
               end
            end
         end else if (!event_req) begin
            if (ack_wait == 0) begin
               event_ack <= 1'b0;
               ack_wait  <= $random(seed) & 3;
            end else begin
               ack_wait <= ack_wait - 1;
            end
         end
      end
   end

   // Port checker
   always @(posedge clk) begin
      mdl_event_t ev;
      int core;
      if (arst_n) begin
         core = int'(event_core);
         if (event_req && !req_q) begin
            check_value(event_ack, 1'b0, "req rose while ack high");
            check_value(mdl_exp[core].size() > 0, 1'b1, "event not expected on this core");
            ev = mdl_exp[core].pop_front();
            check_value(event_code, ev.code, "event code");
            check_value(event_data, ev.data, "event data");
            check_value(event_time, ev.stamp, "event timestamp");
            held_fields <= {event_code, event_core, event_data, event_time};
         end else if (event_req) begin
            check_value({event_code, event_core, event_data, event_time}, held_fields,
                        "fields changed while req high");
         end
         if (done) begin
            check_value(cores_all_exited(), 1'b1, "done before every core exited");
            check_value(!model_empty() || event_req || event_ack, 1'b0,
                        "done while events pending");
            done_seen <= 1'b1;
         end else begin
            check_value(done_seen, 1'b0, "done fell");
         end
         req_q <= event_req;
      end
   end

   // Guard against a stalled handshake
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Simulation timed out after %0d cycles", cycle_count);
         $display("Verification failed");
         $fatal(1);
      end
   end

   initial begin
      logic [31:0] insn;
      logic [4:0]  reg_sel;
      int          r;
      clk          = 1'b0;
      arst_n       = 1'b0;
      trace_valid  = '0;
      trace_insn   = '0;
      trace_wben   = '0;
      trace_wbreg  = '0;
      trace_wbdata = '0;
      event_ack    = 1'b0;
      ack_paused   = 1'b0;
      ack_wait     = 0;
      req_q        = 1'b0;
      done_seen    = 1'b0;
      held_fields  = '0;
      cycle_count  = 0;
      for (int c = 0; c < NUM_CORES; c++) begin
         cooldown[c] = 0;
      end
      reset_model();
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;

      // Mixed register writes and spaced no-ops
      for (int i = 0; i < MAIN_CYCLES; i++) begin
         @(posedge clk);
         for (int c = 0; c < NUM_CORES; c++) begin
            cooldown[c]++;
            r       = $random(seed) & 15;
            reg_sel = ($random(seed) & 1) ? trace_pkg::REG_R3 : 5'($random(seed));
            if ((cooldown[c] >= NOP_GAP) && (r < 2)) begin
               case ($random(seed) & 3)
                  0:       insn = {trace_pkg::NOP_OPCODE, trace_pkg::NOP_K_PUTCHAR};
                  1:       insn = {trace_pkg::NOP_OPCODE, 16'h0008};
                  default: insn = {trace_pkg::NOP_OPCODE, trace_pkg::NOP_K_REPORT};
               endcase
               cooldown[c] = 0;
               drive_lane(c, 1'b1, insn, 1'($random(seed)), reg_sel, $random(seed));
            end else if (r < 10) begin
               insn = $random(seed);
               if (insn[31:16] == trace_pkg::NOP_OPCODE) begin
                  insn[31:16] = 16'h0;
               end
               drive_lane(c, 1'b1, insn, 1'($random(seed)), reg_sel, $random(seed));
            end else begin
               drive_lane(c, 1'b0, 32'h0, 1'b0, 5'd0, 32'h0);
            end
         end
      end
      idle_cycles(1);
      wait_drain();
      check_value(overflow, 1'b0, "overflow during spaced traffic");

      // Host stalls so the third no-op on core 0 is lost
      ack_paused <= 1'b1;
      for (int n = 0; n < 3; n++) begin
         send_nop(0, trace_pkg::NOP_K_REPORT);
         idle_cycles(4);
      end
      drop_newest_event(0);
      check_value(overflow, 1'b1, "overflow after third stalled no-op");
      ack_paused <= 1'b0;
      wait_drain();

      // Both cores exit and later no-ops are ignored
      send_nop(0, trace_pkg::NOP_K_EXIT);
      idle_cycles(4);
      send_nop(1, trace_pkg::NOP_K_EXIT);
      idle_cycles(4);
      for (int c = 0; c < NUM_CORES; c++) begin
         send_nop(c, trace_pkg::NOP_K_REPORT);
         idle_cycles(3);
         send_nop(c, trace_pkg::NOP_K_PUTCHAR);
         idle_cycles(3);
      end
      while (!done) begin
         @(posedge clk);
      end
      check_value(model_empty(), 1'b1, "events left at done");
      repeat (20) @(posedge clk);
      check_value(done, 1'b1, "done held");
      $display("Verification passed");
      $finish;
   end

endmodule

// File: verilog/trace_unit.sv
// Execution trace monitor top level
`timescale 1ns/100ps

module trace_unit #(
   parameter int NUM_CORES = 2,
   parameter int TS_WIDTH  = 16
) (
   input  logic                                      clk_i,
   input  logic                                      arst_n_i,
   // Writeback traces, one lane per core
   input  logic [NUM_CORES-1:0]                      trace_valid_i,
   input  logic [NUM_CORES*trace_pkg::INSN_W-1:0]    trace_insn_i,
   input  logic [NUM_CORES-1:0]                      trace_wben_i,
   input  logic [NUM_CORES*trace_pkg::REG_W-1:0]     trace_wbreg_i,
   input  logic [NUM_CORES*trace_pkg::XLEN-1:0]      trace_wbdata_i,
   // Host port
   output logic                                      event_req_o,
   input  logic                                      event_ack_i,
   output trace_pkg::event_code_e                    event_code_o,
   output logic [((NUM_CORES > 1) ? $clog2(NUM_CORES) : 1)-1:0] event_core_o,
   output logic [trace_pkg::XLEN-1:0]                event_data_o,
   output logic [TS_WIDTH-1:0]                       event_time_o,
   output logic                                      done_o,
   output logic                                      overflow_o
);

   localparam int CODE_W = trace_pkg::CODE_W;
   localparam int INSN_W = trace_pkg::INSN_W;
   localparam int REG_W  = trace_pkg::REG_W;
   localparam int XLEN   = trace_pkg::XLEN;

   logic [TS_WIDTH-1:0]           cur_time;
   logic [NUM_CORES-1:0]          slot_full;
   logic [NUM_CORES*CODE_W-1:0]   slot_code;
   logic [NUM_CORES*XLEN-1:0]     slot_data;
   logic [NUM_CORES*TS_WIDTH-1:0] slot_time;
   logic [NUM_CORES-1:0]          slot_pop;
   logic [NUM_CORES-1:0]          core_exited;
   logic [NUM_CORES-1:0]          core_overflow;

   // Any lost event on any core
   assign overflow_o = |core_overflow;

   cycle_timer #(
      .TS_WIDTH (TS_WIDTH)
   ) u_timer (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .time_o   (cur_time)
   );

   // One decoder per core lane
   for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
      core_trace_decoder #(
         .TS_WIDTH (TS_WIDTH)
      ) u_decoder (
         .clk_i      (clk_i),
         .arst_n_i   (arst_n_i),
         .valid_i    (trace_valid_i[i]),
         .insn_i     (trace_insn_i[i*INSN_W +: INSN_W]),
         .wben_i     (trace_wben_i[i]),
         .wbreg_i    (trace_wbreg_i[i*REG_W +: REG_W]),
         .wbdata_i   (trace_wbdata_i[i*XLEN +: XLEN]),
         .time_i     (cur_time),
         .pop_i      (slot_pop[i]),
         .full_o     (slot_full[i]),
         .code_o     (slot_code[i*CODE_W +: CODE_W]),
         .data_o     (slot_data[i*XLEN +: XLEN]),
         .time_o     (slot_time[i*TS_WIDTH +: TS_WIDTH]),
         .exited_o   (core_exited[i]),
         .overflow_o (core_overflow[i])
      );
   end

   event_fsm #(
      .NUM_CORES (NUM_CORES),
      .TS_WIDTH  (TS_WIDTH)
   ) u_fsm (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .slot_full_i  (slot_full),
      .slot_code_i  (slot_code),
      .slot_data_i  (slot_data),
      .slot_time_i  (slot_time),
      .exited_i     (core_exited),
      .slot_pop_o   (slot_pop),
      .event_req_o  (event_req_o),
      .event_ack_i  (event_ack_i),
      .event_code_o (event_code_o),
      .event_core_o (event_core_o),
      .event_data_o (event_data_o),
      .event_time_o (event_time_o),
      .done_o       (done_o)
   );

endmodule

// File: verilog/event_fsm.sv
// Event drain and host handshake
`timescale 1ns/100ps

module event_fsm #(
   parameter int NUM_CORES = 2,
   parameter int TS_WIDTH  = 16
) (
   input  logic                                      clk_i,
   input  logic                                      arst_n_i,
   // Per-core event slots, packed side by side
   input  logic [NUM_CORES-1:0]                      slot_full_i,
   input  logic [NUM_CORES*trace_pkg::CODE_W-1:0]    slot_code_i,
   input  logic [NUM_CORES*trace_pkg::XLEN-1:0]      slot_data_i,
   input  logic [NUM_CORES*TS_WIDTH-1:0]             slot_time_i,
   input  logic [NUM_CORES-1:0]                      exited_i,
   output logic [NUM_CORES-1:0]                      slot_pop_o,
   // Host port
   output logic                                      event_req_o,
   input  logic                                      event_ack_i,
   output trace_pkg::event_code_e                    event_code_o,
   output logic [((NUM_CORES > 1) ? $clog2(NUM_CORES) : 1)-1:0] event_core_o,
   output logic [trace_pkg::XLEN-1:0]                event_data_o,
   output logic [TS_WIDTH-1:0]                       event_time_o,
   output logic                                      done_o
);

   localparam int IDX_W  = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;
   localparam int CODE_W = trace_pkg::CODE_W;

   trace_pkg::fsm_state_e state_q;
   logic [IDX_W-1:0]      last_q;
   logic [IDX_W-1:0]      grant_idx;
   logic                  grant_valid;
   logic                  launch;
   logic                  all_exited;

   // Round-robin search, starting after the core last served
   always_comb begin
      int cand;
      grant_valid = 1'b0;
      grant_idx   = last_q;
      for (int off = 1; off <= NUM_CORES; off++) begin
         cand = (int'(last_q) + off) % NUM_CORES;
         if (!grant_valid && slot_full_i[cand]) begin
            grant_valid = 1'b1;
            grant_idx   = IDX_W'(cand);
         end
      end
   end

   // Take a slot only while the port is free
   assign launch = (state_q == trace_pkg::ST_IDLE) && grant_valid;

   // One-cycle pop pulse to the chosen decoder
   always_comb begin
      slot_pop_o = '0;
      if (launch) begin
         slot_pop_o[grant_idx] = 1'b1;
      end
   end

   assign event_req_o = (state_q == trace_pkg::ST_REQ);
   assign all_exited  = &exited_i;

   // Four-phase master, done is sticky until reset
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= trace_pkg::ST_IDLE;
         last_q  <= IDX_W'(NUM_CORES - 1);
         done_o  <= 1'b0;
      end else begin
         case (state_q)
            trace_pkg::ST_IDLE: begin
               if (launch) begin
                  state_q <= trace_pkg::ST_REQ;
                  last_q  <= grant_idx;
               end
            end
            trace_pkg::ST_REQ: begin
               // Drop req once ack is seen
               if (event_ack_i) begin
                  state_q <= trace_pkg::ST_RELEASE;
               end
            end
            trace_pkg::ST_RELEASE: begin
               // Host must release ack before the next req
               if (!event_ack_i) begin
                  state_q <= trace_pkg::ST_IDLE;
               end
            end
            default: begin
               state_q <= trace_pkg::ST_IDLE;
            end
         endcase
         if (all_exited && !(|slot_full_i) && (state_q == trace_pkg::ST_IDLE)) begin
            done_o <= 1'b1;
         end
      end
   end

   // Output holding registers, loaded together with the pop
   always_ff @(posedge clk_i) begin
      if (launch) begin
         event_code_o <= trace_pkg::event_code_e'(slot_code_i[grant_idx*CODE_W +: CODE_W]);
         event_core_o <= grant_idx;
         event_data_o <= slot_data_i[grant_idx*trace_pkg::XLEN +: trace_pkg::XLEN];
         event_time_o <= slot_time_i[grant_idx*TS_WIDTH +: TS_WIDTH];
      end
   end

   // req is withdrawn only after the host answered
   a_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      event_req_o && !event_ack_i |=> event_req_o);

   // Fields stay put from req rise until ack falls
   a_fields_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (state_q != trace_pkg::ST_IDLE) |=>
         $stable({event_code_o, event_core_o, event_data_o, event_time_o}));

   // Never drain two decoders at once
   a_pop_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(slot_pop_o));

endmodule

// File: verilog/core_trace_decoder.sv
// Per-core trace decoder
`timescale 1ns/100ps

module core_trace_decoder #(
   parameter int TS_WIDTH = 16
) (
   input  logic                           clk_i,
   input  logic                           arst_n_i,
   // Writeback trace of one core
   input  logic                           valid_i,
   input  logic [trace_pkg::INSN_W-1:0]   insn_i,
   input  logic                           wben_i,
   input  logic [trace_pkg::REG_W-1:0]    wbreg_i,
   input  logic [trace_pkg::XLEN-1:0]     wbdata_i,
   // Current timestamp
   input  logic [TS_WIDTH-1:0]            time_i,
   // Slot drained by the FSM
   input  logic                           pop_i,
   output logic                           full_o,
   output trace_pkg::event_code_e         code_o,
   output logic [trace_pkg::XLEN-1:0]     data_o,
   output logic [TS_WIDTH-1:0]            time_o,
   output logic                           exited_o,
   output logic                           overflow_o
);

   logic [trace_pkg::XLEN-1:0] r3_q;
   logic                       is_nop;
   logic                       k_known;
   logic                       new_event;
   logic                       slot_load;
   trace_pkg::event_code_e     new_code;
   logic [trace_pkg::XLEN-1:0] new_data;

   // Special no-op matched on the upper half only
   assign is_nop = valid_i && (insn_i[31:16] == trace_pkg::NOP_OPCODE);

   // K field decode, unknown values are dropped
   always_comb begin
      k_known  = 1'b1;
      new_code = trace_pkg::EV_REPORT;
      case (insn_i[15:0])
         trace_pkg::NOP_K_EXIT:    new_code = trace_pkg::EV_EXIT;
         trace_pkg::NOP_K_REPORT:  new_code = trace_pkg::EV_REPORT;
         trace_pkg::NOP_K_PUTCHAR: new_code = trace_pkg::EV_PUTCHAR;
         default:                  k_known  = 1'b0;
      endcase
   end

   // Value before this instruction's own writeback
   // putchar keeps only the character byte
   assign new_data = (new_code == trace_pkg::EV_PUTCHAR) ?
                     {{(trace_pkg::XLEN-8){1'b0}}, r3_q[7:0]} : r3_q;

   // Nothing after exit counts
   assign new_event = is_nop && k_known && !exited_o;

   // Slot free, or being popped at this very edge
   assign slot_load = new_event && (!full_o || pop_i);

   // Shadow r3, updated at the same edge as the core writeback
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r3_q <= '0;
      end else if (valid_i && wben_i && (wbreg_i == trace_pkg::REG_R3)) begin
         r3_q <= wbdata_i;
      end
   end

   // Slot occupancy plus the sticky exit and overflow flags
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         full_o     <= 1'b0;
         exited_o   <= 1'b0;
         overflow_o <= 1'b0;
      end else begin
         if (slot_load) begin
            full_o <= 1'b1;
         end else if (pop_i) begin
            full_o <= 1'b0;
         end
         if (new_event && (new_code == trace_pkg::EV_EXIT)) begin
            exited_o <= 1'b1;
         end
         // Slot still held, event lost
         if (new_event && full_o && !pop_i) begin
            overflow_o <= 1'b1;
         end
      end
   end

   // Event payload and timestamp
   always_ff @(posedge clk_i) begin
      if (slot_load) begin
         code_o <= new_code;
         data_o <= new_data;
         time_o <= time_i;
      end
   end

   // FSM pops only a slot it has seen full
   a_pop_when_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      pop_i |-> full_o);

   // Termination detection relies on exit staying set
   a_exit_sticky: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      exited_o |=> exited_o);

endmodule

// File: verilog/cycle_timer.sv
// Event timestamp counter
`timescale 1ns/100ps

module cycle_timer #(
   parameter int TS_WIDTH = 16
) (
   input  logic                clk_i,
   input  logic                arst_n_i,
   output logic [TS_WIDTH-1:0] time_o
);

   // Zero in the first cycle after reset release
   // Plus one at every rising edge from then on
   // Wraps at TS_WIDTH bits with no saturation
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         time_o <= '0;
      end else begin
         time_o <= time_o + 1'b1;
      end
   end

   // Shared by every decoder, so all events stamp against one timebase

endmodule

// File: verilog/trace_pkg.sv
// Trace monitor shared definitions
package trace_pkg;

   // Datapath and trace field widths
   localparam int XLEN   = 32;
   localparam int INSN_W = 32;
   localparam int REG_W  = 5;
   localparam int CODE_W = 2;

   // Register that carries the value passed with report and putchar
   localparam logic [REG_W-1:0] REG_R3 = 5'd3;

   // Special no-op, upper half of the instruction word
   localparam logic [15:0] NOP_OPCODE = 16'h1500;

   // K field of the special no-op, lower half of the instruction word
   localparam logic [15:0] NOP_K_EXIT    = 16'h0001;
   localparam logic [15:0] NOP_K_REPORT  = 16'h0002;
   localparam logic [15:0] NOP_K_PUTCHAR = 16'h0004;

   // Event codes reported on the host port
   typedef enum logic [CODE_W-1:0] {
      EV_EXIT    = 2'd0,
      EV_REPORT  = 2'd1,
      EV_PUTCHAR = 2'd2
   } event_code_e;

   // Four-phase master states
   typedef enum logic [1:0] {
      // Waiting for a pending slot
      ST_IDLE    = 2'd0,
      // req high, waiting for ack
      ST_REQ     = 2'd1,
      // req low, waiting for ack to drop
      ST_RELEASE = 2'd2
   } fsm_state_e;

endpackage
